/* files.f */
design/calc_pkg.sv
design/calc_operand_bypass.sv
design/calc_pipe_int.sv
design/calc_pipe_mul.sv
design/calc_stage_pipe.sv
design/calc_comp_pipe.sv
design/calc_status_gen.sv
design/calc_top.sv
tests/calc_tb.sv

/* Bender.yml */
package:
  name: calc

sources:
  - design/calc_pkg.sv
  - design/calc_operand_bypass.sv
  - design/calc_pipe_int.sv
  - design/calc_pipe_mul.sv
  - design/calc_stage_pipe.sv
  - design/calc_comp_pipe.sv
  - design/calc_status_gen.sv
  - design/calc_top.sv
  - target: test
    files:
      - tests/calc_tb.sv

/* tests/calc_tb.sv */
`timescale 1ns/1ps

module calc_tb;

  // One dispatch slot as seen at the DUT inputs and its expected result
  typedef struct packed {
    logic                                   v;
    logic                                   poison;
    logic                                   flush;
    logic                                   mul;
    logic                                   wr;
    logic [calc_pkg::reg_addr_width_lp-1:0] rd;
    logic [calc_pkg::pc_width_lp-1:0]       pc;
    logic [calc_pkg::data_width_lp-1:0]     data;
  } disp_rec_s;

  logic                             clk;
  logic                             rst;
  logic                             flush;
  calc_pkg::calc_dispatch_pkt_s     dispatch_pkt;
  calc_pkg::calc_commit_pkt_s       commit_pkt;
  calc_pkg::calc_wb_pkt_s           iwb_pkt;
  calc_pkg::calc_status_s           calc_status;

  logic [calc_pkg::data_width_lp-1:0]     exp_data;
  logic [calc_pkg::data_width_lp-1:0]     arch_rf [0:31];
  logic [calc_pkg::data_width_lp-1:0]     true_rf [0:31];
  logic                                   pend_v;
  logic [calc_pkg::reg_addr_width_lp-1:0] pend_rd;
  logic [calc_pkg::data_width_lp-1:0]     pend_data;
  logic [calc_pkg::pc_width_lp-1:0]       next_pc;
  disp_rec_s                              hist [0:calc_pkg::pipe_stage_els_lp];
  int                                     seed;
  int                                     error_count;
  int                                     check_count;

  calc_top i_dut
    (.clk_i(clk)
    , .rst_i(rst)
    , .dispatch_pkt_i(dispatch_pkt)
    , .flush_i(flush)
    , .commit_pkt_o(commit_pkt)
    , .iwb_pkt_o(iwb_pkt)
    , .calc_status_o(calc_status)
    );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] calc_ref
    (input calc_pkg::calc_op_e op
    , input logic [31:0] a
    , input logic [31:0] b
    );
    case (op)
      calc_pkg::e_op_add: return a + b;
      calc_pkg::e_op_sub: return a - b;
      calc_pkg::e_op_and: return a & b;
      calc_pkg::e_op_or:  return a | b;
      calc_pkg::e_op_xor: return a ^ b;
      calc_pkg::e_op_sll: return a << b[4:0];
      calc_pkg::e_op_srl: return a >> b[4:0];
      default:            return a * b;
    endcase
  endfunction

  task automatic flag_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    error_count++;
    $display("mismatch %s expected %0h actual %0h at %0t", name, exp, act, $time);
  endtask

  // Stage s record dies by its own poison or flush or by a flush one cycle later
  function automatic logic killed_at(input int s);
    return hist[s+1].poison | hist[s+1].flush | hist[s].flush;
  endfunction

  function automatic logic in_flight();
    return hist[0].v | hist[1].v | hist[2].v | hist[3].v;
  endfunction

  // Any live stage in the DUT means results are still on the way
  function automatic logic dut_busy();
    logic busy;
    busy = 1'b0;
    for (int s = 0; s < calc_pkg::pipe_stage_els_lp; s++)
      busy = busy | calc_status.dep_status[s].instr_v;
    return busy;
  endfunction

  task automatic score_writeback;
    logic exp_v;
    exp_v = hist[3].v & hist[3].wr & ~killed_at(calc_pkg::wb_stage_lp);
    check_count++;
    if (iwb_pkt.rd_w_v !== exp_v)
      flag_mismatch("iwb_pkt_o.rd_w_v", exp_v, iwb_pkt.rd_w_v);
    else if (exp_v)
    begin
      if (iwb_pkt.rd_addr !== hist[3].rd)
        flag_mismatch("iwb_pkt_o.rd_addr", hist[3].rd, iwb_pkt.rd_addr);
      if (iwb_pkt.rd_data !== hist[3].data)
        flag_mismatch("iwb_pkt_o.rd_data", hist[3].data, iwb_pkt.rd_data);
    end
    if (iwb_pkt.rd_w_v === 1'b1 && iwb_pkt.rd_addr != '0)
      arch_rf[iwb_pkt.rd_addr] = iwb_pkt.rd_data;
  endtask

  task automatic compare_commit;
    logic                             exp_v;
    logic [calc_pkg::pc_width_lp-1:0] exp_npc;
    exp_v   = hist[2].v & ~killed_at(calc_pkg::commit_stage_lp);
    exp_npc = hist[1].v ? hist[1].pc : '0;
    check_count++;
    if (commit_pkt.v !== exp_v)
      flag_mismatch("commit_pkt_o.v", exp_v, commit_pkt.v);
    else if (exp_v)
    begin
      if (commit_pkt.pc !== hist[2].pc)
        flag_mismatch("commit_pkt_o.pc", hist[2].pc, commit_pkt.pc);
      if (commit_pkt.npc !== exp_npc)
        flag_mismatch("commit_pkt_o.npc", exp_npc, commit_pkt.npc);
    end
  endtask

  task automatic verify_status;
    calc_pkg::calc_status_s exp_s;
    calc_pkg::calc_status_s act_s;
    logic                   live;
    exp_s = '0;
    act_s = calc_status;
    exp_s.commit_v = hist[2].v & ~killed_at(calc_pkg::commit_stage_lp);
    for (int s = 0; s < calc_pkg::pipe_stage_els_lp; s++)
    begin
      live = hist[s+1].v & ~killed_at(s);
      exp_s.dep_status[s].instr_v   = live;
      exp_s.dep_status[s].int_iwb_v = live & ~hist[s+1].mul & hist[s+1].wr;
      exp_s.dep_status[s].mul_iwb_v = live & hist[s+1].mul & hist[s+1].wr;
      // rd only matters for a live instruction
      if (live)
        exp_s.dep_status[s].rd_addr = hist[s+1].rd;
      else
        act_s.dep_status[s].rd_addr = '0;
    end
    check_count++;
    if (act_s !== exp_s)
      flag_mismatch("calc_status_o", exp_s, act_s);
  endtask

  always @(negedge clk)
  begin
    if (rst !== 1'b0)
    begin
      for (int i = 0; i <= calc_pkg::pipe_stage_els_lp; i++)
        hist[i] = '0;
    end
    else
    begin
      for (int i = calc_pkg::pipe_stage_els_lp; i > 0; i--)
        hist[i] = hist[i-1];
      hist[0].v      = dispatch_pkt.v;
      hist[0].poison = dispatch_pkt.poison;
      hist[0].flush  = flush;
      hist[0].mul    = (dispatch_pkt.op == calc_pkg::e_op_mul);
      hist[0].wr     = dispatch_pkt.irf_w_v;
      hist[0].rd     = dispatch_pkt.rd_addr;
      hist[0].pc     = dispatch_pkt.pc;
      hist[0].data   = exp_data;
      score_writeback();
      compare_commit();
      verify_status();
    end
  end

  task automatic drive_cycle
    (input logic v
    , input calc_pkg::calc_op_e op
    , input logic [4:0] rd
    , input logic [4:0] rs1
    , input logic [4:0] rs2
    , input logic poison
    , input logic kill
    );
    calc_pkg::calc_dispatch_pkt_s pkt;
    logic [31:0]                  result;
    @(posedge clk);
    // Last cycle's instruction survives unless flushed now
    if (pend_v && !kill)
      true_rf[pend_rd] = pend_data;
    result    = calc_ref(op, true_rf[rs1], true_rf[rs2]);
    pend_v    = v && (rd != '0) && !poison && !kill;
    pend_rd   = rd;
    pend_data = result;
    pkt = '0;
    if (v)
    begin
      pkt.v        = 1'b1;
      pkt.poison   = poison;
      pkt.op       = op;
      pkt.pc       = next_pc;
      pkt.rs1_addr = rs1;
      pkt.rs2_addr = rs2;
      pkt.rd_addr  = rd;
      pkt.irf_w_v  = (rd != '0);
      // Register file reads are stale for producers still in flight
      pkt.rs1      = arch_rf[rs1];
      pkt.rs2      = arch_rf[rs2];
      next_pc      = next_pc + 4;
    end
    dispatch_pkt <= pkt;
    flush        <= kill;
    exp_data     <= result;
  endtask

  task automatic dispatch_op(input calc_pkg::calc_op_e op, input int rd, input int rs1,
                             input int rs2);
    drive_cycle(1'b1, op, rd[4:0], rs1[4:0], rs2[4:0], 1'b0, 1'b0);
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++)
      drive_cycle(1'b0, calc_pkg::e_op_add, '0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic wait_drain;
    int   cycles;
    logic busy;
    cycles = 0;
    do
    begin
      @(negedge clk);
      busy = (dut_busy() !== 1'b0);
      idle_cycles(1);
      cycles++;
      busy = busy | in_flight();
    end
    while (busy && cycles < 10);
    if (busy)
    begin
      error_count++;
      $display("pipeline did not drain within %0d cycles at %0t", cycles, $time);
    end
  endtask

  task automatic run_random(input int n, input logic with_mul, input logic with_kills);
    logic [31:0]        r;
    calc_pkg::calc_op_e op;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic               prev_mul;
    logic [4:0]         prev_rd;
    prev_mul = 1'b0;
    prev_rd  = '0;
    for (int i = 0; i < n; i++)
    begin
      r  = $random(seed);
      op = calc_pkg::calc_op_e'(r[2:0]);
      if (!with_mul && op == calc_pkg::e_op_mul)
        op = calc_pkg::e_op_add;
      rd  = {2'b00, r[5:3]};
      rs1 = {2'b00, r[8:6]};
      rs2 = {2'b00, r[11:9]};
      // Multiply result is not forwardable one cycle after dispatch
      if (prev_mul && rs1 == prev_rd)
        rs1 = '0;
      if (prev_mul && rs2 == prev_rd)
        rs2 = '0;
      drive_cycle(!with_kills || r[14:12] != '0, op, rd, rs1, rs2,
                  with_kills && r[18:15] == '0, with_kills && r[22:19] == '0);
      prev_mul = (!with_kills || r[14:12] != '0) && op == calc_pkg::e_op_mul;
      prev_rd  = rd;
    end
  endtask

  initial
  begin
    seed         = 93570;
    error_count  = 0;
    check_count  = 0;
    pend_v       = 1'b0;
    pend_rd      = '0;
    pend_data    = '0;
    next_pc      = 32'h0000_1000;
    rst          = 1'b1;
    flush        = 1'b0;
    dispatch_pkt = '0;
    exp_data     = '0;
    for (int i = 0; i < 32; i++)
    begin
      arch_rf[i] = (i == 0) ? '0 : $random(seed);
      true_rf[i] = arch_rf[i];
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    idle_cycles(3);
    @(negedge clk);
    check_count++;
    if (calc_status !== '0)
      flag_mismatch("calc_status_o", '0, calc_status);

    run_random(40, 1'b0, 1'b0);
    wait_drain();

    // Back-to-back products
    for (int i = 0; i < 6; i++)
      dispatch_op(calc_pkg::e_op_mul, 20 + i, 1 + i, 7 - i);
    wait_drain();

    // Dependency chain and then consumers of multiplies two cycles later
    dispatch_op(calc_pkg::e_op_add, 9, 1, 2);
    dispatch_op(calc_pkg::e_op_sub, 10, 9, 3);
    dispatch_op(calc_pkg::e_op_xor, 11, 10, 9);
    dispatch_op(calc_pkg::e_op_sll, 12, 11, 1);
    dispatch_op(calc_pkg::e_op_srl, 13, 12, 11);
    dispatch_op(calc_pkg::e_op_or, 9, 13, 12);
    dispatch_op(calc_pkg::e_op_mul, 14, 9, 10);
    dispatch_op(calc_pkg::e_op_and, 1, 2, 3);
    dispatch_op(calc_pkg::e_op_add, 15, 14, 9);
    dispatch_op(calc_pkg::e_op_mul, 16, 15, 14);
    idle_cycles(1);
    dispatch_op(calc_pkg::e_op_sub, 17, 16, 15);
    wait_drain();

    // x0 reads while something targets x0
    dispatch_op(calc_pkg::e_op_add, 0, 5, 6);
    dispatch_op(calc_pkg::e_op_or, 3, 0, 0);
    dispatch_op(calc_pkg::e_op_add, 4, 0, 5);
    dispatch_op(calc_pkg::e_op_sub, 0, 4, 3);
    dispatch_op(calc_pkg::e_op_xor, 6, 0, 4);
    wait_drain();

    // Flush kills this cycle's and last cycle's dispatch
    dispatch_op(calc_pkg::e_op_add, 5, 1, 2);
    dispatch_op(calc_pkg::e_op_add, 6, 5, 5);
    drive_cycle(1'b1, calc_pkg::e_op_add, 7, 6, 5, 1'b0, 1'b1);
    dispatch_op(calc_pkg::e_op_add, 8, 6, 7);
    dispatch_op(calc_pkg::e_op_or, 9, 7, 6);
    drive_cycle(1'b1, calc_pkg::e_op_xor, 2, 1, 3, 1'b1, 1'b0);
    dispatch_op(calc_pkg::e_op_add, 10, 2, 2);
    dispatch_op(calc_pkg::e_op_mul, 11, 10, 5);
    drive_cycle(1'b0, calc_pkg::e_op_add, 0, 0, 0, 1'b0, 1'b1);
    dispatch_op(calc_pkg::e_op_add, 12, 11, 10);
    wait_drain();

    run_random(200, 1'b1, 1'b1);
    wait_drain();

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* design/calc_top.sv */
`timescale 1ns/1ps

module calc_top
  (input  logic                          clk_i
  , input  logic                         rst_i

  , input  calc_pkg::calc_dispatch_pkt_s dispatch_pkt_i
  , input  logic                         flush_i

  , output calc_pkg::calc_commit_pkt_s   commit_pkt_o
  , output calc_pkg::calc_wb_pkt_s       iwb_pkt_o
  , output calc_pkg::calc_status_s       calc_status_o
  );

  calc_pkg::calc_dispatch_pkt_s repaired_pkt;
  calc_pkg::calc_dispatch_pkt_s reservation;

  calc_pkg::calc_wb_pkt_s [calc_pkg::pipe_stage_els_lp:1]  fwd;
  calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp-1:0] stage_r;
  calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp:1]   stage_n;

  logic [calc_pkg::data_width_lp-1:0] int_data;
  logic [calc_pkg::data_width_lp-1:0] mul_data;

  calc_operand_bypass bypass
    (.clk_i(clk_i)
    , .dispatch_pkt_i(dispatch_pkt_i)
    , .fwd_i(fwd)
    , .repaired_pkt_o(repaired_pkt)
    , .reservation_o(reservation)
    );

  // Integer pipe, 1 cycle
  calc_pipe_int pipe_int
    (.reservation_i(reservation)
    , .data_o(int_data)
    );

  // Multiply pipe, 2 cycles
  calc_pipe_mul pipe_mul
    (.clk_i(clk_i)
    , .reservation_i(reservation)
    , .data_o(mul_data)
    );

  calc_stage_pipe stage_pipe
    (.clk_i(clk_i)
    , .rst_i(rst_i)
    , .repaired_pkt_i(repaired_pkt)
    , .flush_i(flush_i)
    , .stage_r_o(stage_r)
    , .stage_n_o(stage_n)
    );

  calc_comp_pipe comp_pipe
    (.clk_i(clk_i)
    , .stage_r_i(stage_r)
    , .stage_n_i(stage_n)
    , .int_data_i(int_data)
    , .mul_data_i(mul_data)
    , .fwd_o(fwd)
    , .iwb_pkt_o(iwb_pkt_o)
    );

  calc_status_gen status_gen
    (.stage_r_i(stage_r)
    , .stage_n_i(stage_n)
    , .commit_pkt_o(commit_pkt_o)
    , .calc_status_o(calc_status_o)
    );

endmodule

/* design/calc_status_gen.sv */
`timescale 1ns/1ps

module calc_status_gen
  (input  calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp-1:0] stage_r_i
  , input  calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp:1]   stage_n_i

  , output calc_pkg::calc_commit_pkt_s                              commit_pkt_o
  , output calc_pkg::calc_status_s                                  calc_status_o
  );

  logic [calc_pkg::pipe_stage_els_lp-1:0] stage_live;

  always_comb
  begin
    commit_pkt_o.v   = stage_r_i[calc_pkg::commit_stage_lp].v
                       & ~stage_r_i[calc_pkg::commit_stage_lp].poison_v;
    commit_pkt_o.pc  = stage_r_i[calc_pkg::commit_stage_lp].pc;
    // Next pc is whatever sits right behind, zero when that slot is empty
    commit_pkt_o.npc = stage_r_i[calc_pkg::commit_stage_lp-1].v
                       ? stage_r_i[calc_pkg::commit_stage_lp-1].pc
                       : '0;
  end

  always_comb
  begin
    calc_status_o.commit_v = commit_pkt_o.v;
    for (int i = 0; i < calc_pkg::pipe_stage_els_lp; i++)
    begin
      // Next-value poison so a flush this cycle is already visible
      stage_live[i] = stage_r_i[i].v & ~stage_n_i[i+1].poison_v;

      calc_status_o.dep_status[i].instr_v   = stage_live[i];
      calc_status_o.dep_status[i].int_iwb_v = stage_live[i] & stage_r_i[i].pipe_int_v
                                              & stage_r_i[i].irf_w_v;
      calc_status_o.dep_status[i].mul_iwb_v = stage_live[i] & stage_r_i[i].pipe_mul_v
                                              & stage_r_i[i].irf_w_v;
      calc_status_o.dep_status[i].rd_addr   = stage_r_i[i].rd_addr;
    end
  end

endmodule

/* design/calc_comp_pipe.sv */
`timescale 1ns/1ps

module calc_comp_pipe
  (input  logic                                                     clk_i

  , input  calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp-1:0] stage_r_i
  , input  calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp:1]   stage_n_i
  , input  logic [calc_pkg::data_width_lp-1:0]                      int_data_i
  , input  logic [calc_pkg::data_width_lp-1:0]                      mul_data_i

  , output calc_pkg::calc_wb_pkt_s [calc_pkg::pipe_stage_els_lp:1]  fwd_o
  , output calc_pkg::calc_wb_pkt_s                                  iwb_pkt_o
  );

  logic [calc_pkg::pipe_stage_els_lp:1][calc_pkg::data_width_lp-1:0]   comp_data_n;
  logic [calc_pkg::pipe_stage_els_lp-1:1][calc_pkg::data_width_lp-1:0] comp_data_r;

  // Single issue with fixed latencies, so only one pipe can finish into a stage
  always_comb
  begin
    comp_data_n[1] = stage_r_i[0].pipe_int_v ? int_data_i : '0;
    comp_data_n[2] = stage_r_i[1].pipe_mul_v ? mul_data_i : comp_data_r[1];
    comp_data_n[3] = comp_data_r[2];
  end

  always_ff @(posedge clk_i)
  begin
    comp_data_r <= comp_data_n[calc_pkg::pipe_stage_els_lp-1:1];
  end

  // Forwarding view of next-stage results
  always_comb
  begin
    for (int i = 1; i <= calc_pkg::pipe_stage_els_lp; i++)
    begin
      fwd_o[i].rd_w_v  = stage_n_i[i].v & stage_n_i[i].irf_w_v & ~stage_n_i[i].poison_v;
      fwd_o[i].rd_addr = stage_n_i[i].rd_addr;
      fwd_o[i].rd_data = comp_data_n[i];
    end
  end

  assign iwb_pkt_o.rd_w_v  = stage_r_i[calc_pkg::wb_stage_lp].v
                             & stage_r_i[calc_pkg::wb_stage_lp].irf_w_v
                             & ~stage_r_i[calc_pkg::wb_stage_lp].poison_v;
  assign iwb_pkt_o.rd_addr = stage_r_i[calc_pkg::wb_stage_lp].rd_addr;
  assign iwb_pkt_o.rd_data = comp_data_r[calc_pkg::wb_stage_lp];

endmodule

/* design/calc_stage_pipe.sv */
`timescale 1ns/1ps

module calc_stage_pipe
  (input  logic                                                     clk_i
  , input  logic                                                    rst_i

  , input  calc_pkg::calc_dispatch_pkt_s                            repaired_pkt_i
  , input  logic                                                    flush_i

  , output calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp-1:0] stage_r_o
  , output calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp:1]   stage_n_o
  );

  calc_pkg::calc_stage_s                                  stage_isd;
  calc_pkg::calc_stage_s [calc_pkg::pipe_stage_els_lp-1:0] stage_r;

  // Strip the dispatch packet down to what later stages need
  always_comb
  begin
    stage_isd.v          = repaired_pkt_i.v;
    stage_isd.poison_v   = repaired_pkt_i.poison | flush_i;
    stage_isd.pc         = repaired_pkt_i.pc;
    stage_isd.rd_addr    = repaired_pkt_i.rd_addr;
    stage_isd.irf_w_v    = repaired_pkt_i.irf_w_v;
    stage_isd.pipe_mul_v = (repaired_pkt_i.op == calc_pkg::e_op_mul);
    stage_isd.pipe_int_v = ~stage_isd.pipe_mul_v;
  end

  always_comb
  begin
    for (int i = 1; i <= calc_pkg::pipe_stage_els_lp; i++)
    begin
      stage_n_o[i] = stage_r[i-1];
    end
    // Flush still catches the instruction in stage 0
    stage_n_o[1].poison_v = stage_r[0].poison_v | flush_i;
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= {stage_n_o[calc_pkg::pipe_stage_els_lp-1:1], stage_isd};
    if (rst_i)
    begin
      for (int i = 0; i < calc_pkg::pipe_stage_els_lp; i++)
      begin
        stage_r[i].v <= 1'b0;
      end
    end
  end

  assign stage_r_o = stage_r;

endmodule

/* design/calc_pipe_mul.sv */
`timescale 1ns/1ps

module calc_pipe_mul
  (input  logic                                clk_i
  , input  calc_pkg::calc_dispatch_pkt_s       reservation_i
  , output logic [calc_pkg::data_width_lp-1:0] data_o
  );

  logic [15:0] a_lo, a_hi, b_lo, b_hi;

  logic [31:0] ll_n, ll_r;
  logic [15:0] lh_n, lh_r;
  logic [15:0] hl_n, hl_r;
  logic [15:0] cross_sum;

  assign a_lo = reservation_i.rs1[15:0];
  assign a_hi = reservation_i.rs1[31:16];
  assign b_lo = reservation_i.rs2[15:0];
  assign b_hi = reservation_i.rs2[31:16];

  // Cross terms only reach the upper half, so their low 16 bits suffice
  assign ll_n = a_lo * b_lo;
  assign lh_n = a_lo * b_hi;
  assign hl_n = a_hi * b_lo;

  // New product every cycle
  always_ff @(posedge clk_i)
  begin
    ll_r <= ll_n;
    lh_r <= lh_n;
    hl_r <= hl_n;
  end

  assign cross_sum = lh_r + hl_r;
  assign data_o    = ll_r + {cross_sum, 16'h0000};

endmodule

/* design/calc_pipe_int.sv */
`timescale 1ns/1ps

module calc_pipe_int
  (input  calc_pkg::calc_dispatch_pkt_s        reservation_i
  , output logic [calc_pkg::data_width_lp-1:0] data_o
  );

  logic [calc_pkg::data_width_lp-1:0] rs1;
  logic [calc_pkg::data_width_lp-1:0] rs2;
  logic [4:0]                         shamt;

  assign rs1   = reservation_i.rs1;
  assign rs2   = reservation_i.rs2;
  assign shamt = rs2[4:0];

  always_comb
  begin
    case (reservation_i.op)
      calc_pkg::e_op_add: data_o = rs1 + rs2;
      calc_pkg::e_op_sub: data_o = rs1 - rs2;
      calc_pkg::e_op_and: data_o = rs1 & rs2;
      calc_pkg::e_op_or:  data_o = rs1 | rs2;
      calc_pkg::e_op_xor: data_o = rs1 ^ rs2;
      calc_pkg::e_op_sll: data_o = rs1 << shamt;
      // Logical, zero fill
      calc_pkg::e_op_srl: data_o = rs1 >> shamt;
      // Multiply goes down the other pipe
      default:            data_o = '0;
    endcase
  end

endmodule

/* design/calc_operand_bypass.sv */
`timescale 1ns/1ps

module calc_operand_bypass
  (input  logic                                                   clk_i

  , input  calc_pkg::calc_dispatch_pkt_s                          dispatch_pkt_i
  , input  calc_pkg::calc_wb_pkt_s [calc_pkg::pipe_stage_els_lp:1] fwd_i

  , output calc_pkg::calc_dispatch_pkt_s                          repaired_pkt_o
  , output calc_pkg::calc_dispatch_pkt_s                          reservation_o
  );

  function automatic logic [calc_pkg::data_width_lp-1:0] forward_operand
    (input logic [calc_pkg::reg_addr_width_lp-1:0]                 addr
    , input logic [calc_pkg::data_width_lp-1:0]                    rf_data
    , input calc_pkg::calc_wb_pkt_s [calc_pkg::pipe_stage_els_lp:1] fwd
    );
    logic [calc_pkg::data_width_lp-1:0] result;

    result = rf_data;
    // Walk oldest to youngest so the youngest match wins
    for (int i = calc_pkg::pipe_stage_els_lp; i >= 1; i--)
    begin
      if (fwd[i].rd_w_v && (addr != '0) && (fwd[i].rd_addr == addr))
        result = fwd[i].rd_data;
    end
    return result;
  endfunction

  always_comb
  begin
    repaired_pkt_o     = dispatch_pkt_i;
    repaired_pkt_o.rs1 = forward_operand(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1, fwd_i);
    repaired_pkt_o.rs2 = forward_operand(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2, fwd_i);
  end

  // Reservation register feeds both execution pipes
  always_ff @(posedge clk_i)
  begin
    reservation_o <= repaired_pkt_o;
  end

endmodule

/* design/calc_pkg.sv */
package calc_pkg;

  localparam int data_width_lp     = 32;
  localparam int reg_addr_width_lp = 5;
  localparam int pc_width_lp       = 32;

  // Registered stages 0..2, next-value view covers 1..3
  localparam int pipe_stage_els_lp = 3;
  localparam int commit_stage_lp   = 1;
  localparam int wb_stage_lp       = 2;

  typedef enum logic [2:0] {
    e_op_add = 3'd0,
    e_op_sub = 3'd1,
    e_op_and = 3'd2,
    e_op_or  = 3'd3,
    e_op_xor = 3'd4,
    e_op_sll = 3'd5,
    e_op_srl = 3'd6,
    e_op_mul = 3'd7
  } calc_op_e;

  typedef struct packed {
    logic                         v;
    logic                         poison;
    calc_op_e                     op;
    logic [pc_width_lp-1:0]       pc;
    logic [reg_addr_width_lp-1:0] rs1_addr;
    logic [reg_addr_width_lp-1:0] rs2_addr;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic                         irf_w_v;
    logic [data_width_lp-1:0]     rs1;
    logic [data_width_lp-1:0]     rs2;
  } calc_dispatch_pkt_s;

  // Bookkeeping that travels beside the results
  typedef struct packed {
    logic                         v;
    logic                         poison_v;
    logic [pc_width_lp-1:0]       pc;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic                         irf_w_v;
    logic                         pipe_int_v;
    logic                         pipe_mul_v;
  } calc_stage_s;

  typedef struct packed {
    logic                         rd_w_v;
    logic [reg_addr_width_lp-1:0] rd_addr;
    logic [data_width_lp-1:0]     rd_data;
  } calc_wb_pkt_s;

  typedef struct packed {
    logic                   v;
    logic [pc_width_lp-1:0] pc;
    logic [pc_width_lp-1:0] npc;
  } calc_commit_pkt_s;

  typedef struct packed {
    logic                         instr_v;
    logic                         int_iwb_v;
    logic                         mul_iwb_v;
    logic [reg_addr_width_lp-1:0] rd_addr;
  } calc_dep_status_s;

  typedef struct packed {
    calc_dep_status_s [pipe_stage_els_lp-1:0] dep_status;
    logic                                     commit_v;
  } calc_status_s;

endpackage
